// File: softmc_pkg.sv
`default_nettype none

package softmc_pkg;

  // ********************
  // Widths
  // ********************
  localparam int instr_w = 32;
  localparam int data_w  = 64;
  localparam int row_w   = 17;
  localparam int bank_w  = 3;
  localparam int wait_w  = 16;

  // Cycles from read command on the pins to valid dq_in
  localparam int read_latency = 6;

  // ********************
  // Queue depths
  // ********************
  localparam int iq_depth = 16;
  localparam int rq_depth = 8;

  // Occupancy width of the readback queue, 0..rq_depth
  localparam int rq_cnt_w = $clog2(rq_depth + 1);

  // Instruction opcodes, top nibble of the instruction word
  typedef enum logic [3:0] {
    op_nop    = 4'd0,
    op_busdir = 4'd1,
    op_wait   = 4'd4,
    op_ddr    = 4'd8
  } opcode_e;

  // Instruction word layout
  // Wait count sits in the low wait_w bits, bus direction in bit 0
  typedef struct packed {
    opcode_e                             opcode;
    logic                                ras_n;
    logic                                cas_n;
    logic                                we_n;
    logic [bank_w-1:0]                   bank;
    logic [instr_w-4-3-bank_w-row_w-1:0] rsvd;
    logic [row_w-1:0]                    addr;
  } instr_t;

  // Command pins as driven toward the DRAM
  typedef struct packed {
    logic              cs_n;
    logic              ras_n;
    logic              cas_n;
    logic              we_n;
    logic [bank_w-1:0] ba;
    logic [row_w-1:0]  addr;
  } ddr_cmd_t;

  // Deselect, all strobes high
  localparam ddr_cmd_t ddr_cmd_idle = '{
    cs_n:  1'b1,
    ras_n: 1'b1,
    cas_n: 1'b1,
    we_n:  1'b1,
    ba:    '0,
    addr:  '0
  };

endpackage

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int width = 32,
  parameter int depth = 16
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         in_valid,
  output logic                        in_ready,
  input  wire  [width-1:0]            in_data,
  output logic                        out_valid,
  input  wire                         out_ready,
  output logic [width-1:0]            out_data,
  output logic [$clog2(depth+1)-1:0]  count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count_next;
  logic             push;
  logic             pop;

  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;
  assign out_data = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Flags are registered so both handshakes stay low through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count_next;
      in_ready  <= count_next < depth;
      out_valid <= count_next != '0;
    end
  end

endmodule

`default_nettype wire

// File: instr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer (
  input  wire                   ddr3_ck_n_sdram,
  input  wire                   rst,
  input  wire                   instr_valid,
  output logic                  instr_ready,
  input  wire softmc_pkg::instr_t instr,
  input  wire                   read_room,
  output softmc_pkg::ddr_cmd_t  ddr_cmd,
  output logic                  read_issue
);

  logic [softmc_pkg::wait_w-1:0] wait_cnt;
  logic [softmc_pkg::wait_w-1:0] wait_next;
  logic                          read_mode;
  logic                          read_mode_next;
  logic                          is_read;
  logic                          read_stall;
  logic                          pop;
  softmc_pkg::ddr_cmd_t          cmd_next;
  logic                          issue_next;

  // ********************
  // Pop control
  // ********************

  // Read class is CAS low with RAS and WE high
  assign is_read = instr_valid
                   && (instr.opcode == softmc_pkg::op_ddr)
                   && !instr.cas_n && instr.ras_n && instr.we_n;

  // Hold a read until the capture side has a slot for its word
  assign read_stall = read_mode && is_read && !read_room;

  assign instr_ready = (wait_cnt == '0) && !read_stall;
  assign pop         = instr_valid && instr_ready;

  // ********************
  // Decode
  // ********************
  always_comb begin
    cmd_next       = softmc_pkg::ddr_cmd_idle;
    issue_next     = 1'b0;
    read_mode_next = read_mode;
    wait_next      = wait_cnt;

    // Count down idle cycles of a running wait
    if (wait_cnt != '0) begin
      wait_next = wait_cnt - 1'b1;
    end

    if (pop) begin
      case (instr.opcode)
        softmc_pkg::op_nop: begin
          cmd_next = softmc_pkg::ddr_cmd_idle;
        end
        softmc_pkg::op_busdir: begin
          read_mode_next = instr.addr[0];
        end
        softmc_pkg::op_wait: begin
          wait_next = instr.addr[softmc_pkg::wait_w-1:0];
        end
        softmc_pkg::op_ddr: begin
          cmd_next.cs_n  = 1'b0;
          cmd_next.ras_n = instr.ras_n;
          cmd_next.cas_n = instr.cas_n;
          cmd_next.we_n  = instr.we_n;
          cmd_next.ba    = instr.bank;
          cmd_next.addr  = instr.addr;
          // Only reads on a bus in read mode return data
          issue_next     = is_read && read_mode;
        end
        default: begin
          cmd_next = softmc_pkg::ddr_cmd_idle;
        end
      endcase
    end
  end

  // Registered command pins, idle unless a command was popped
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (rst) begin
      ddr_cmd    <= softmc_pkg::ddr_cmd_idle;
      read_issue <= 1'b0;
      read_mode  <= 1'b0;
      wait_cnt   <= '0;
    end else begin
      ddr_cmd    <= cmd_next;
      read_issue <= issue_next;
      read_mode  <= read_mode_next;
      wait_cnt   <= wait_next;
    end
  end

endmodule

`default_nettype wire

// File: read_capture.sv
`timescale 1ns/1ps
`default_nettype none

module read_capture (
  input  wire                                ddr3_ck_n_sdram,
  input  wire                                rst,
  input  wire                                read_issue,
  input  wire  [softmc_pkg::data_w-1:0]      dq_in,
  input  wire  [softmc_pkg::rq_cnt_w-1:0]    rq_count,
  output logic                               read_room,
  output logic                               cap_valid,
  output logic [softmc_pkg::data_w-1:0]      cap_data
);

  logic [softmc_pkg::read_latency-2:0] flag_pipe;
  logic [softmc_pkg::read_latency-1:0] flags;
  logic [softmc_pkg::rq_cnt_w-1:0]     in_flight;
  logic [softmc_pkg::rq_cnt_w:0]       pending;

  // Stage 0 is the read on the pins this cycle
  assign flags = {flag_pipe, read_issue};

  // Reads on the pins, in the delay line or captured, plus queued words
  assign pending   = in_flight + rq_count + read_issue;
  assign read_room = pending < softmc_pkg::rq_depth;

  // ********************
  // Latency tracking
  // ********************
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (rst) begin
      flag_pipe <= '0;
      in_flight <= '0;
    end else begin
      flag_pipe <= flags[softmc_pkg::read_latency-2:0];
      case ({read_issue, cap_valid})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Sample on the edge the last flag is seen
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (rst) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= flags[softmc_pkg::read_latency-1];
    end
  end

  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (flags[softmc_pkg::read_latency-1]) begin
      cap_data <= dq_in;
    end
  end

endmodule

`default_nettype wire

// File: softmc_top.sv
`timescale 1ns/1ps
`default_nettype none

module softmc_top (
  input  wire                            ddr3_ck_n_sdram,
  input  wire                            rst,
  input  wire                            app_valid,
  output logic                           app_ready,
  input  wire softmc_pkg::instr_t        app_instr,
  output softmc_pkg::ddr_cmd_t           ddr_cmd,
  input  wire  [softmc_pkg::data_w-1:0]  dq_in,
  output logic                           rdback_valid,
  input  wire                            rdback_ready,
  output logic [softmc_pkg::data_w-1:0]  rdback_data
);

  logic                              iq_valid;
  logic                              iq_ready;
  softmc_pkg::instr_t                iq_instr;
  logic                              read_room;
  logic                              read_issue;
  logic                              cap_valid;
  logic [softmc_pkg::data_w-1:0]     cap_data;
  logic [softmc_pkg::rq_cnt_w-1:0]   rq_count;

  // ********************
  // Instruction path
  // ********************
  sync_fifo #(
    .width (softmc_pkg::instr_w),
    .depth (softmc_pkg::iq_depth)
  ) u_instr_queue (
    .clk       (ddr3_ck_n_sdram),
    .rst       (rst),
    .in_valid  (app_valid),
    .in_ready  (app_ready),
    .in_data   (app_instr),
    .out_valid (iq_valid),
    .out_ready (iq_ready),
    .out_data  (iq_instr),
    .count     ()
  );

  instr_sequencer u_instr_sequencer (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst             (rst),
    .instr_valid     (iq_valid),
    .instr_ready     (iq_ready),
    .instr           (iq_instr),
    .read_room       (read_room),
    .ddr_cmd         (ddr_cmd),
    .read_issue      (read_issue)
  );

  // ********************
  // Readback path
  // ********************
  read_capture u_read_capture (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst             (rst),
    .read_issue      (read_issue),
    .dq_in           (dq_in),
    .rq_count        (rq_count),
    .read_room       (read_room),
    .cap_valid       (cap_valid),
    .cap_data        (cap_data)
  );

  // Room accounting keeps this queue from ever refusing a capture
  sync_fifo #(
    .width (softmc_pkg::data_w),
    .depth (softmc_pkg::rq_depth)
  ) u_rdback_queue (
    .clk       (ddr3_ck_n_sdram),
    .rst       (rst),
    .in_valid  (cap_valid),
    .in_ready  (),
    .in_data   (cap_data),
    .out_valid (rdback_valid),
    .out_ready (rdback_ready),
    .out_data  (rdback_data),
    .count     (rq_count)
  );

endmodule

`default_nettype wire

// File: tb_softmc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_softmc_top;

  localparam int step_limit = 4000;
  localparam int lat = softmc_pkg::read_latency;

  logic                          ddr3_ck_n_sdram;
  logic                          rst;
  logic                          app_valid;
  logic                          app_ready;
  softmc_pkg::instr_t            app_instr;
  softmc_pkg::ddr_cmd_t          ddr_cmd;
  logic [softmc_pkg::data_w-1:0] dq_in;
  logic                          rdback_valid;
  logic                          rdback_ready;
  logic [softmc_pkg::data_w-1:0] rdback_data;

  // Scoreboard queues, filled while the input file is read
  softmc_pkg::ddr_cmd_t          exp_cmd_q[$];
  int                            exp_gap_q[$];
  logic [softmc_pkg::data_w-1:0] exp_word_q[$];
  // Responder delay line, slot 0 drives dq_in next
  logic [softmc_pkg::data_w-1:0] resp_data [lat];
  logic                          resp_valid [lat];
  int errors [1:5];
  int checks;
  int cyc;
  int last_cmd_cyc;
  int gap_min;
  int hold_left;
  int words_got;
  int words_file;
  int total;
  int t;
  bit running;
  bit saw_full;

  softmc_top u_softmc_top (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst             (rst),
    .app_valid       (app_valid),
    .app_ready       (app_ready),
    .app_instr       (app_instr),
    .ddr_cmd         (ddr_cmd),
    .dq_in           (dq_in),
    .rdback_valid    (rdback_valid),
    .rdback_ready    (rdback_ready),
    .rdback_data     (rdback_data)
  );

  initial begin
    ddr3_ck_n_sdram = 1'b0;
    forever #50 ddr3_ck_n_sdram = ~ddr3_ck_n_sdram;
  end

  // Readback word: c0de plus bank on top, address below
  function automatic logic [63:0] word_for(logic [2:0] bank, logic [16:0] addr);
    word_for = {32'hc0de_0000 + 32'(bank), 15'd0, addr};
  endfunction

  task automatic compare_value(int test, string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors[test]++;
      $display("FAIL %s got=0x%0h exp=0x%0h", name, got, exp);
    end
  endtask

  task automatic flag_error(int test, string what);
    errors[test]++;
    $display("ERROR %s", what);
  endtask

  task automatic print_test(int n, string name);
    $display("test %0d %s: %0d errors", n, name, errors[n]);
  endtask

  // ********************
  // Command monitor and DRAM responder
  // ********************
  always @(negedge ddr3_ck_n_sdram) begin
    if (running) begin
      cyc++;
      if (ddr_cmd !== softmc_pkg::ddr_cmd_idle) begin
        if (exp_cmd_q.size() == 0) begin
          flag_error(2, $sformatf("command 0x%0h appeared with none expected", ddr_cmd));
        end else begin
          compare_value(2, "ddr_cmd", ddr_cmd, exp_cmd_q.pop_front());
          gap_min = exp_gap_q.pop_front();
          if (last_cmd_cyc >= 0 && cyc - last_cmd_cyc < gap_min) begin
            flag_error(3, $sformatf("command gap %0d below minimum %0d",
                                    cyc - last_cmd_cyc, gap_min));
          end
          last_cmd_cyc = cyc;
        end
      end
    end
  end

  // Command seen here went out one half cycle ago, data due lat edges after it
  always @(negedge ddr3_ck_n_sdram) begin
    dq_in = resp_valid[0] ? resp_data[0] : 64'hdead;
    for (int i = 0; i < lat - 1; i++) begin
      resp_valid[i] = resp_valid[i+1];
      resp_data[i]  = resp_data[i+1];
    end
    resp_valid[lat-1] = 1'b0;
    if (!ddr_cmd.cs_n && ddr_cmd.ras_n && !ddr_cmd.cas_n && ddr_cmd.we_n) begin
      resp_valid[lat-2] = 1'b1;
      resp_data[lat-2]  = word_for(ddr_cmd.ba, ddr_cmd.addr);
    end
  end

  // Readback drain, a held stretch first, then random stalls
  always @(negedge ddr3_ck_n_sdram) begin
    if (running) begin
      if (hold_left > 0) begin
        rdback_ready = 1'b0;
        hold_left--;
      end else begin
        rdback_ready = ($urandom % 4) != 0;
      end
      if (rdback_valid && rdback_ready) begin
        words_got++;
        if (exp_word_q.size() == 0) begin
          flag_error(4, "readback word arrived with none expected");
        end else begin
          compare_value(4, "rdback_data", rdback_data, exp_word_q.pop_front());
        end
      end
    end
  end

  task automatic push_instr(softmc_pkg::instr_t ins);
    int n;
    app_valid = 1'b0;
    repeat ($urandom % 3) @(negedge ddr3_ck_n_sdram);
    app_valid = 1'b1;
    app_instr = ins;
    n = 0;
    while (!app_ready && n < step_limit) begin
      saw_full = 1'b1;
      @(negedge ddr3_ck_n_sdram);
      n++;
    end
    if (!app_ready) begin
      flag_error(5, "timed out waiting for app_ready");
    end
    @(negedge ddr3_ck_n_sdram);
    app_valid = 1'b0;
  endtask

  // ********************
  // File-driven stimulus
  // ********************
  task automatic feed_file();
    int fd;
    int wait_acc;
    string line;
    byte tag;
    logic [31:0] val;
    bit read_mode;
    softmc_pkg::instr_t ins;
    softmc_pkg::ddr_cmd_t cmd;
    wait_acc = 0;
    read_mode = 1'b0;
    fd = $fopen("softmc_input.txt", "r");
    if (fd == 0) begin
      flag_error(5, "could not open softmc_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() >= 3 && line[0] != "#") begin
        void'($sscanf(line, "%c %h", tag, val));
        if (tag == "P") begin
          hold_left = val;
        end else if (tag == "E") begin
          words_file = val;
        end else if (tag == "I") begin
          ins = softmc_pkg::instr_t'(val);
          case (ins.opcode)
            softmc_pkg::op_busdir: read_mode = ins.addr[0];
            softmc_pkg::op_wait:   wait_acc += ins.addr[15:0];
            softmc_pkg::op_ddr: begin
              cmd.cs_n  = 1'b0;
              cmd.ras_n = ins.ras_n;
              cmd.cas_n = ins.cas_n;
              cmd.we_n  = ins.we_n;
              cmd.ba    = ins.bank;
              cmd.addr  = ins.addr;
              exp_cmd_q.push_back(cmd);
              exp_gap_q.push_back(1 + wait_acc);
              wait_acc = 0;
              if (read_mode && ins.ras_n && !ins.cas_n && ins.we_n) begin
                exp_word_q.push_back(word_for(ins.bank, ins.addr));
              end
            end
            default: ;
          endcase
          push_instr(ins);
        end else begin
          flag_error(5, "unknown tag in input file");
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    void'($urandom(32'hd84a_9e2c));
    rst = 1'b1;
    app_valid = 1'b0;
    app_instr = '0;
    rdback_ready = 1'b0;
    dq_in = 64'hdead;
    for (int i = 0; i < lat; i++) begin
      resp_valid[i] = 1'b0;
      resp_data[i]  = '0;
    end
    for (int i = 1; i <= 5; i++) begin
      errors[i] = 0;
    end
    checks = 0;
    cyc = 0;
    last_cmd_cyc = -1;
    hold_left = 0;
    words_got = 0;
    words_file = 0;
    running = 1'b0;
    saw_full = 1'b0;
    repeat (3) @(negedge ddr3_ck_n_sdram);
    compare_value(1, "ddr_cmd", ddr_cmd, softmc_pkg::ddr_cmd_idle);
    compare_value(1, "rdback_valid", rdback_valid, 1'b0);
    compare_value(1, "app_ready", app_ready, 1'b0);
    rst = 1'b0;
    running = 1'b1;
    t = 0;
    while (!app_ready && t < step_limit) begin
      @(negedge ddr3_ck_n_sdram);
      t++;
    end
    if (!app_ready) begin
      flag_error(1, "app_ready never rose after reset");
    end
    print_test(1, "reset state");
    feed_file();
    // Drain everything still expected
    t = 0;
    while ((exp_cmd_q.size() != 0 || exp_word_q.size() != 0) && t < step_limit) begin
      @(negedge ddr3_ck_n_sdram);
      t++;
    end
    if (exp_cmd_q.size() != 0) begin
      flag_error(2, "timed out with commands still expected");
    end
    if (exp_word_q.size() != 0) begin
      flag_error(4, "timed out with readback words still expected");
    end
    // Quiet window to catch stray commands or words
    repeat (2 * lat + 8) @(negedge ddr3_ck_n_sdram);
    print_test(2, "command order");
    print_test(3, "command spacing");
    print_test(4, "readback data");
    if (!saw_full) begin
      flag_error(5, "app_ready never dropped while readback was held");
    end
    compare_value(5, "rdback_count", words_got, words_file);
    print_test(5, "back-pressure");
    total = errors[1] + errors[2] + errors[3] + errors[4] + errors[5];
    $display("tests=5 checks=%0d errors=%0d", checks, total);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: softmc_input.txt
# Column 1 tag: I instruction word, P rdback_ready low for N cycles, E readback word count
# Column 2 value in hex
E 0000000d
I 86400120
I 40000003
I 8a400010
I 88400018
I 10000001
I 40000002
I 8a400020
I 8a80abcd
I 00000000
I 8ac1ffff
P 000000c8
I 8b400001
I 8b400002
I 8b400003
I 8b400004
I 8b400005
I 8b400006
I 8b400007
I 8b400008
I 8b400009
I 8b40000a
I 84400000
I 40000004
I 86800200
I 00000000
I 88800044
I 40000001
I 00000000
I 00000000
I 10000000
I 8a800050
I 40000002
I 84800000
I 00000000
I 86c00300
I 00000000
I 00000000

// File: sources.f
softmc_pkg.sv
sync_fifo.sv
instr_sequencer.sv
read_capture.sv
softmc_top.sv
tb_softmc_top.sv
